/* common/ex_pkg.sv */
package ex_pkg;

  // Data word and register file sizes
  localparam int XLEN       = 32;
  localparam int RF_ADDR_W  = 5;
  localparam int CSR_ADDR_W = 12;

  // Iterative multiplier takes one operand slice per step
  localparam int MULT_STEPS   = 4;
  localparam int MULT_SLICE_W = XLEN / MULT_STEPS;
  localparam int MULT_STEP_W  = $clog2(MULT_STEPS);

  // Scratch CSR window, base must stay aligned to the window size
  localparam logic [CSR_ADDR_W-1:0] CSR_SCRATCH_BASE = 12'h340;
  localparam int CSR_SCRATCH_NUM = 4;
  localparam int CSR_IDX_W       = $clog2(CSR_SCRATCH_NUM);

  // ALU operators, the last four are comparisons
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11
  } alu_op_e;

  // Low word or unsigned high word of the product
  typedef enum logic {
    MUL_LO = 1'b0,
    MUL_HU = 1'b1
  } mult_op_e;

  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  // Multiplier sequencer states
  typedef enum logic [1:0] {
    MS_IDLE = 2'b00,
    MS_RUN  = 2'b01,
    MS_DONE = 2'b10
  } mult_state_e;

endpackage

/* hw/ex_stage/ex_alu.sv */
`timescale 1ns/1ps

module ex_alu (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    enable_i,
  input  ex_pkg::alu_op_e         operator_i,
  input  logic [ex_pkg::XLEN-1:0] operand_a_i,
  input  logic [ex_pkg::XLEN-1:0] operand_b_i,
  output logic [ex_pkg::XLEN-1:0] result_o,
  output logic                    comparison_result_o,
  output logic                    ready_o
);
  import ex_pkg::*;

  logic                    sub_mode;
  logic [XLEN-1:0]         adder_b;
  logic [XLEN:0]           adder_sum;
  logic                    is_equal;
  logic                    lt_unsigned;
  logic                    lt_signed;
  logic [$clog2(XLEN)-1:0] shamt;

  // Everything except ADD subtracts, compares reuse the subtractor
  assign sub_mode  = (operator_i != ALU_ADD);
  assign adder_b   = sub_mode ? ~operand_b_i : operand_b_i;
  assign adder_sum = {1'b0, operand_a_i} + {1'b0, adder_b} + {{XLEN{1'b0}}, sub_mode};

  // No carry out of a + ~b + 1 means a < b unsigned
  assign lt_unsigned = !adder_sum[XLEN];
  // Differing signs decide by the sign of a
  assign lt_signed   = (operand_a_i[XLEN-1] ^ operand_b_i[XLEN-1]) ?
                       operand_a_i[XLEN-1] : lt_unsigned;
  assign is_equal    = (operand_a_i == operand_b_i);

  assign shamt = operand_b_i[$clog2(XLEN)-1:0];

  // Shared flag for SLT results and branch decisions
  always_comb
  begin
    case (operator_i)
      ALU_EQ:   comparison_result_o = is_equal;
      ALU_NE:   comparison_result_o = !is_equal;
      ALU_SLT:  comparison_result_o = lt_signed;
      ALU_SLTU: comparison_result_o = lt_unsigned;
      default:  comparison_result_o = 1'b0;
    endcase
  end

  always_comb
  begin
    case (operator_i)
      ALU_ADD, ALU_SUB: result_o = adder_sum[XLEN-1:0];
      ALU_AND:          result_o = operand_a_i & operand_b_i;
      ALU_OR:           result_o = operand_a_i | operand_b_i;
      ALU_XOR:          result_o = operand_a_i ^ operand_b_i;
      ALU_SLL:          result_o = operand_a_i << shamt;
      ALU_SRL:          result_o = operand_a_i >> shamt;
      ALU_SRA:          result_o = $unsigned($signed(operand_a_i) >>> shamt);
      // Compares return the flag as a 0 or 1 word
      default:          result_o = {{(XLEN-1){1'b0}}, comparison_result_o};
    endcase
  end

  // Single cycle, never stalls
  assign ready_o = 1'b1;

  a_op_known: assert property (@(posedge clk) disable iff (!rst_n)
    enable_i |-> !$isunknown(operator_i))
    else $error("ALU enabled with unknown operator");

endmodule

/* hw/ex_stage/ex_mult.sv */
`timescale 1ns/1ps

module ex_mult (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    kill_i,
  input  logic                    enable_i,
  input  ex_pkg::mult_op_e        operator_i,
  input  logic [ex_pkg::XLEN-1:0] op_a_i,
  input  logic [ex_pkg::XLEN-1:0] op_b_i,
  input  logic                    ex_ready_i,
  output logic [ex_pkg::XLEN-1:0] result_o,
  output logic                    ready_o
);
  import ex_pkg::*;

  mult_state_e              state_q;
  logic [MULT_STEP_W-1:0]   step_q;
  logic [MULT_STEP_W-1:0]   slice_idx;
  logic [MULT_SLICE_W-1:0]  b_slice;
  logic [2*XLEN-1:0]        partial;
  logic [2*XLEN-1:0]        acc_base;
  logic [2*XLEN-1:0]        acc_q;

  ////////////////////////////////////////////////////////////////////////////
  // Shift-add datapath
  ////////////////////////////////////////////////////////////////////////////

  // Slice 0 is consumed in the idle cycle that starts the operation
  assign slice_idx = (state_q == MS_IDLE) ? '0 : step_q;
  assign b_slice   = op_b_i[slice_idx*MULT_SLICE_W +: MULT_SLICE_W];
  assign partial   = ({{XLEN{1'b0}}, op_a_i} *
                      {{(2*XLEN-MULT_SLICE_W){1'b0}}, b_slice})
                     << (slice_idx * MULT_SLICE_W);
  // Fresh start from zero when idle
  assign acc_base  = (state_q == MS_IDLE) ? '0 : acc_q;

  always_ff @(posedge clk)
  begin
    // Frozen once done so the result survives back-pressure
    if (state_q != MS_DONE)
    begin
      acc_q <= acc_base + partial;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= MS_IDLE;
      step_q  <= '0;
    end
    else if (kill_i)
    begin
      // Abort whatever is in flight
      state_q <= MS_IDLE;
    end
    else
    begin
      case (state_q)
        MS_IDLE:
        begin
          if (enable_i)
          begin
            state_q <= MS_RUN;
            step_q  <= MULT_STEP_W'(1);
          end
        end
        MS_RUN:
        begin
          step_q <= step_q + 1'b1;
          if (step_q == MULT_STEP_W'(MULT_STEPS-1))
          begin
            state_q <= MS_DONE;
          end
        end
        MS_DONE:
        begin
          if (ex_ready_i)
          begin
            state_q <= MS_IDLE;
          end
        end
        default: state_q <= MS_IDLE;
      endcase
    end
  end

  // Idle is only ready when no multiply is requested
  assign ready_o  = (state_q == MS_DONE) || ((state_q == MS_IDLE) && !enable_i);
  assign result_o = (operator_i == MUL_HU) ? acc_q[2*XLEN-1:XLEN] : acc_q[XLEN-1:0];

endmodule

/* hw/ex_stage/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          halt_i,
  input  logic                          kill_i,
  input  logic                          issue_valid_i,
  input  logic                          alu_en_i,
  input  logic                          mult_en_i,
  input  logic                          csr_en_i,
  input  logic                          branch_i,
  input  logic                          rf_we_i,
  input  ex_pkg::alu_op_e               alu_operator_i,
  input  ex_pkg::mult_op_e              mult_operator_i,
  input  ex_pkg::csr_op_e               csr_op_i,
  input  logic [ex_pkg::XLEN-1:0]       operand_a_i,
  input  logic [ex_pkg::XLEN-1:0]       operand_b_i,
  input  logic [ex_pkg::XLEN-1:0]       branch_target_i,
  input  logic [ex_pkg::RF_ADDR_W-1:0]  rf_waddr_i,
  input  logic [ex_pkg::XLEN-1:0]       csr_rdata_i,
  input  logic                          wb_ready_i,
  output logic [ex_pkg::CSR_ADDR_W-1:0] csr_raddr_o,
  output logic                          ex_ready_o,
  output logic                          wb_valid_o,
  output logic                          wb_rf_we_o,
  output logic [ex_pkg::RF_ADDR_W-1:0]  wb_rf_waddr_o,
  output logic [ex_pkg::XLEN-1:0]       wb_rf_wdata_o,
  output logic                          wb_csr_en_o,
  output ex_pkg::csr_op_e               wb_csr_op_o,
  output logic [ex_pkg::CSR_ADDR_W-1:0] wb_csr_addr_o,
  output logic [ex_pkg::XLEN-1:0]       wb_csr_wdata_o,
  output logic                          branch_decision_o,
  output logic [ex_pkg::XLEN-1:0]       branch_target_o
);
  import ex_pkg::*;

  logic [XLEN-1:0] alu_result;
  logic            alu_cmp;
  logic            alu_ready;
  logic [XLEN-1:0] mult_result;
  logic            mult_ready;
  logic            alu_en_g;
  logic            mult_en_g;
  logic            csr_en_g;
  logic            rf_we_g;
  logic            ex_valid;
  logic [XLEN-1:0] rf_wdata;

  // Units only see a live, unkilled instruction
  assign alu_en_g  = alu_en_i  && issue_valid_i && !kill_i;
  assign mult_en_g = mult_en_i && issue_valid_i && !kill_i;
  assign csr_en_g  = csr_en_i  && issue_valid_i && !kill_i;
  assign rf_we_g   = rf_we_i   && issue_valid_i && !kill_i;

  // CSR address rides in the low bits of operand b
  assign csr_raddr_o = operand_b_i[CSR_ADDR_W-1:0];

  // Write-back data select, ALU by default
  always_comb
  begin
    rf_wdata = alu_result;
    if (mult_en_g)
      rf_wdata = mult_result;
    else if (csr_en_g)
      rf_wdata = csr_rdata_i;
  end

  ex_alu alu_i (
    .clk                 (clk),
    .rst_n               (rst_n),
    .enable_i            (alu_en_g),
    .operator_i          (alu_operator_i),
    .operand_a_i         (operand_a_i),
    .operand_b_i         (operand_b_i),
    .result_o            (alu_result),
    .comparison_result_o (alu_cmp),
    .ready_o             (alu_ready)
  );

  ex_mult mult_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .kill_i     (kill_i),
    .enable_i   (mult_en_g),
    .operator_i (mult_operator_i),
    .op_a_i     (operand_a_i),
    .op_b_i     (operand_b_i),
    .ex_ready_i (ex_ready_o),
    .result_o   (mult_result),
    .ready_o    (mult_ready)
  );

  // Branches resolve here and never reach writeback
  assign branch_decision_o = alu_cmp && branch_i && issue_valid_i && !kill_i;
  assign branch_target_o   = branch_target_i;

  ////////////////////////////////////////////////////////////////////////////
  // Handshake and EX/WB register
  ////////////////////////////////////////////////////////////////////////////

  assign ex_valid   = alu_ready && mult_ready && wb_ready_i && issue_valid_i && !kill_i;
  assign ex_ready_o = (alu_ready && mult_ready && wb_ready_i && !halt_i) ||
                      (branch_i && issue_valid_i);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wb_valid_o  <= 1'b0;
      wb_rf_we_o  <= 1'b0;
      wb_csr_en_o <= 1'b0;
    end
    else if (ex_valid)
    begin
      wb_valid_o  <= !branch_i;
      wb_rf_we_o  <= rf_we_g && !branch_i;
      wb_csr_en_o <= csr_en_g && !branch_i;
    end
    else if (wb_ready_i)
    begin
      // Writeback drained and nothing new, bubble
      wb_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (ex_valid)
    begin
      wb_rf_waddr_o  <= rf_waddr_i;
      wb_rf_wdata_o  <= rf_wdata;
      wb_csr_op_o    <= csr_op_i;
      wb_csr_addr_o  <= csr_raddr_o;
      wb_csr_wdata_o <= operand_a_i;
    end
  end

  a_onehot_en: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({alu_en_g, mult_en_g, csr_en_g}))
    else $error("More than one execute unit enabled");

  // A fresh multiply keeps the stage busy for exactly MULT_STEPS cycles
  a_mult_timing: assert property (@(posedge clk) disable iff (!rst_n || kill_i)
    $rose(mult_en_g) |-> (!mult_ready)[*MULT_STEPS] ##1 mult_ready)
    else $error("Multiplier ready timing off");

endmodule

/* hw/csr_scratch.sv */
`timescale 1ns/1ps

module csr_scratch (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [ex_pkg::CSR_ADDR_W-1:0] raddr_i,
  output logic [ex_pkg::XLEN-1:0]       rdata_o,
  input  logic                          we_i,
  input  logic                          wb_valid_i,
  input  logic                          wb_ready_i,
  input  logic [ex_pkg::CSR_ADDR_W-1:0] waddr_i,
  input  ex_pkg::csr_op_e               wop_i,
  input  logic [ex_pkg::XLEN-1:0]       wdata_i
);
  import ex_pkg::*;

  logic [XLEN-1:0]       scratch_q [CSR_SCRATCH_NUM];
  logic [CSR_ADDR_W-1:0] roff;
  logic [CSR_ADDR_W-1:0] woff;
  logic                  rd_hit;
  logic                  wr_fire;
  logic [XLEN-1:0]       wr_old;
  logic [XLEN-1:0]       wr_new;

  // Offsets into the scratch window, out of range wraps high
  assign roff   = raddr_i - CSR_SCRATCH_BASE;
  assign woff   = waddr_i - CSR_SCRATCH_BASE;
  assign rd_hit = (roff < CSR_ADDR_W'(CSR_SCRATCH_NUM));

  // Unmapped addresses read zero
  assign rdata_o = rd_hit ? scratch_q[roff[CSR_IDX_W-1:0]] : '0;

  // Commit only when writeback actually retires the instruction
  assign wr_fire = we_i && wb_valid_i && wb_ready_i && (wop_i != CSR_OP_READ) &&
                   (woff < CSR_ADDR_W'(CSR_SCRATCH_NUM));
  assign wr_old  = scratch_q[woff[CSR_IDX_W-1:0]];

  always_comb
  begin
    case (wop_i)
      CSR_OP_WRITE: wr_new = wdata_i;
      CSR_OP_SET:   wr_new = wr_old | wdata_i;
      CSR_OP_CLEAR: wr_new = wr_old & ~wdata_i;
      default:      wr_new = wr_old;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < CSR_SCRATCH_NUM; i++)
        scratch_q[i] <= '0;
    end
    else if (wr_fire)
    begin
      scratch_q[woff[CSR_IDX_W-1:0]] <= wr_new;
    end
  end

endmodule

/* hw/ex_top.sv */
`timescale 1ns/1ps

module ex_top (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         halt_i,
  input  logic                         kill_i,
  input  logic                         issue_valid_i,
  input  logic                         alu_en_i,
  input  logic                         mult_en_i,
  input  logic                         csr_en_i,
  input  logic                         branch_i,
  input  logic                         rf_we_i,
  input  ex_pkg::alu_op_e              alu_operator_i,
  input  ex_pkg::mult_op_e             mult_operator_i,
  input  ex_pkg::csr_op_e              csr_op_i,
  input  logic [ex_pkg::XLEN-1:0]      operand_a_i,
  input  logic [ex_pkg::XLEN-1:0]      operand_b_i,
  input  logic [ex_pkg::XLEN-1:0]      branch_target_i,
  input  logic [ex_pkg::RF_ADDR_W-1:0] rf_waddr_i,
  input  logic                         wb_ready_i,
  output logic                         ex_ready_o,
  output logic                         wb_valid_o,
  output logic                         wb_rf_we_o,
  output logic [ex_pkg::RF_ADDR_W-1:0] wb_rf_waddr_o,
  output logic [ex_pkg::XLEN-1:0]      wb_rf_wdata_o,
  output logic                         branch_decision_o,
  output logic [ex_pkg::XLEN-1:0]      branch_target_o
);
  import ex_pkg::*;

  // Read side in execute, write side at writeback
  logic [CSR_ADDR_W-1:0] csr_raddr;
  logic [XLEN-1:0]       csr_rdata;
  logic                  wb_csr_en;
  csr_op_e               wb_csr_op;
  logic [CSR_ADDR_W-1:0] wb_csr_addr;
  logic [XLEN-1:0]       wb_csr_wdata;

  ex_stage ex_stage_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .halt_i            (halt_i),
    .kill_i            (kill_i),
    .issue_valid_i     (issue_valid_i),
    .alu_en_i          (alu_en_i),
    .mult_en_i         (mult_en_i),
    .csr_en_i          (csr_en_i),
    .branch_i          (branch_i),
    .rf_we_i           (rf_we_i),
    .alu_operator_i    (alu_operator_i),
    .mult_operator_i   (mult_operator_i),
    .csr_op_i          (csr_op_i),
    .operand_a_i       (operand_a_i),
    .operand_b_i       (operand_b_i),
    .branch_target_i   (branch_target_i),
    .rf_waddr_i        (rf_waddr_i),
    .csr_rdata_i       (csr_rdata),
    .wb_ready_i        (wb_ready_i),
    .csr_raddr_o       (csr_raddr),
    .ex_ready_o        (ex_ready_o),
    .wb_valid_o        (wb_valid_o),
    .wb_rf_we_o        (wb_rf_we_o),
    .wb_rf_waddr_o     (wb_rf_waddr_o),
    .wb_rf_wdata_o     (wb_rf_wdata_o),
    .wb_csr_en_o       (wb_csr_en),
    .wb_csr_op_o       (wb_csr_op),
    .wb_csr_addr_o     (wb_csr_addr),
    .wb_csr_wdata_o    (wb_csr_wdata),
    .branch_decision_o (branch_decision_o),
    .branch_target_o   (branch_target_o)
  );

  // Writeback valid and ready qualify the CSR write
  csr_scratch csr_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .raddr_i    (csr_raddr),
    .rdata_o    (csr_rdata),
    .we_i       (wb_csr_en),
    .wb_valid_i (wb_valid_o),
    .wb_ready_i (wb_ready_i),
    .waddr_i    (wb_csr_addr),
    .wop_i      (wb_csr_op),
    .wdata_i    (wb_csr_wdata)
  );

endmodule

/* verif/tb_ex_top.sv */
`timescale 1ns/1ps

module tb_ex_top;
  import ex_pkg::*;

  // Instruction classes of the stimulus table
  localparam int K_ALU   = 0;
  localparam int K_MUL   = 1;
  localparam int K_CSR   = 2;
  localparam int K_BR    = 3;
  localparam int TIMEOUT = 50;

  typedef struct {
    int              kind;
    alu_op_e         aop;
    mult_op_e        mop;
    csr_op_e         cop;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [4:0]      rd;
    int              kill;
    logic [XLEN-1:0] want;
  } entry_t;

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 halt_i;
  logic                 kill_i;
  logic                 issue_valid_i;
  logic                 alu_en_i;
  logic                 mult_en_i;
  logic                 csr_en_i;
  logic                 branch_i;
  logic                 rf_we_i;
  alu_op_e              alu_operator_i;
  mult_op_e             mult_operator_i;
  csr_op_e              csr_op_i;
  logic [XLEN-1:0]      operand_a_i;
  logic [XLEN-1:0]      operand_b_i;
  logic [XLEN-1:0]      branch_target_i;
  logic [RF_ADDR_W-1:0] rf_waddr_i;
  logic                 wb_ready_i;
  logic                 ex_ready_o;
  logic                 wb_valid_o;
  logic                 wb_rf_we_o;
  logic [RF_ADDR_W-1:0] wb_rf_waddr_o;
  logic [XLEN-1:0]      wb_rf_wdata_o;
  logic                 branch_decision_o;
  logic [XLEN-1:0]      branch_target_o;

  entry_t               tbl[$];
  logic [RF_ADDR_W-1:0] exp_addr[$];
  logic [XLEN-1:0]      exp_data[$];
  logic [XLEN-1:0]      csr_model [CSR_SCRATCH_NUM];
  integer               seed;
  int                   mismatch_cnt = 0;
  int                   fail_cnt = 0;
  logic                 timed_out = 1'b0;
  // Previous cycle left a result stalled in EX/WB
  logic                 hold_q = 1'b0;
  logic [XLEN-1:0]      hold_data;
  logic [RF_ADDR_W-1:0] hold_addr;

  always #10 clk = ~clk;

  ex_top dut_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .halt_i            (halt_i),
    .kill_i            (kill_i),
    .issue_valid_i     (issue_valid_i),
    .alu_en_i          (alu_en_i),
    .mult_en_i         (mult_en_i),
    .csr_en_i          (csr_en_i),
    .branch_i          (branch_i),
    .rf_we_i           (rf_we_i),
    .alu_operator_i    (alu_operator_i),
    .mult_operator_i   (mult_operator_i),
    .csr_op_i          (csr_op_i),
    .operand_a_i       (operand_a_i),
    .operand_b_i       (operand_b_i),
    .branch_target_i   (branch_target_i),
    .rf_waddr_i        (rf_waddr_i),
    .wb_ready_i        (wb_ready_i),
    .ex_ready_o        (ex_ready_o),
    .wb_valid_o        (wb_valid_o),
    .wb_rf_we_o        (wb_rf_we_o),
    .wb_rf_waddr_o     (wb_rf_waddr_o),
    .wb_rf_wdata_o     (wb_rf_wdata_o),
    .branch_decision_o (branch_decision_o),
    .branch_target_o   (branch_target_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic add_entry(input int kind, input alu_op_e aop, input mult_op_e mop,
                           input csr_op_e cop, input logic [XLEN-1:0] a,
                           input logic [XLEN-1:0] b, input logic [4:0] rd,
                           input int kill, input logic [XLEN-1:0] want);
    entry_t e;
    e.kind = kind;
    e.aop  = aop;
    e.mop  = mop;
    e.cop  = cop;
    e.a    = a;
    e.b    = b;
    e.rd   = rd;
    e.kill = kill;
    e.want = want;
    tbl.push_back(e);
  endtask

  task automatic idle_inputs();
    issue_valid_i   = 1'b0;
    kill_i          = 1'b0;
    alu_en_i        = 1'b0;
    mult_en_i       = 1'b0;
    csr_en_i        = 1'b0;
    branch_i        = 1'b0;
    rf_we_i         = 1'b0;
    alu_operator_i  = ALU_ADD;
    mult_operator_i = MUL_LO;
    csr_op_i        = CSR_OP_READ;
    operand_a_i     = '0;
    operand_b_i     = '0;
    branch_target_i = '0;
    rf_waddr_i      = '0;
  endtask

  // Branches borrow the ALU compare, every class but branches writes rd
  task automatic drive_entry(input entry_t e, input int idx, input int cyc);
    issue_valid_i   = 1'b1;
    kill_i          = (cyc == e.kill);
    alu_en_i        = (e.kind == K_ALU) || (e.kind == K_BR);
    mult_en_i       = (e.kind == K_MUL);
    csr_en_i        = (e.kind == K_CSR);
    branch_i        = (e.kind == K_BR);
    rf_we_i         = (e.kind != K_BR);
    alu_operator_i  = e.aop;
    mult_operator_i = e.mop;
    csr_op_i        = e.cop;
    operand_a_i     = e.a;
    operand_b_i     = e.b;
    branch_target_i = 32'h0000_1000 + (32'(idx) << 2);
    rf_waddr_i      = e.rd;
  endtask

  // Writeback stalls about one cycle in four
  task automatic draw_wb_ready();
    wb_ready_i = (($random(seed) & 3) != 0);
  endtask

  // Queue the expected write-back and advance the CSR model
  task automatic record_accept(input entry_t e);
    int                   addr;
    int                   base;
    logic [CSR_IDX_W-1:0] idx;
    logic [XLEN-1:0]      old;
    if (e.kind == K_ALU || e.kind == K_MUL)
    begin
      exp_addr.push_back(e.rd);
      exp_data.push_back(e.want);
    end
    else if (e.kind == K_CSR)
    begin
      addr = int'(e.b[CSR_ADDR_W-1:0]);
      base = int'(CSR_SCRATCH_BASE);
      old  = '0;
      if (addr >= base && addr < base + CSR_SCRATCH_NUM)
      begin
        idx = CSR_IDX_W'(addr - base);
        old = csr_model[idx];
        case (e.cop)
          CSR_OP_WRITE: csr_model[idx] = e.a;
          CSR_OP_SET:   csr_model[idx] = old | e.a;
          CSR_OP_CLEAR: csr_model[idx] = old & ~e.a;
          default:      csr_model[idx] = old;
        endcase
      end
      exp_addr.push_back(e.rd);
      exp_data.push_back(old);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Writeback monitor, one call per cycle between falling and rising edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_wb();
    logic [RF_ADDR_W-1:0] ea;
    logic [XLEN-1:0]      ed;
    if (hold_q)
    begin
      if (wb_valid_o !== 1'b1)
      begin
        mismatch_cnt++;
        $display("MISMATCH at %0t ns: wb_valid_o expected 1 got %b", $time, wb_valid_o);
      end
      if (wb_rf_wdata_o !== hold_data)
      begin
        mismatch_cnt++;
        $display("MISMATCH at %0t ns: wb_rf_wdata_o expected %h got %h",
                 $time, hold_data, wb_rf_wdata_o);
      end
      if (wb_rf_waddr_o !== hold_addr)
      begin
        mismatch_cnt++;
        $display("MISMATCH at %0t ns: wb_rf_waddr_o expected %0d got %0d",
                 $time, hold_addr, wb_rf_waddr_o);
      end
    end
    // Handshake seen now retires at the coming rising edge
    if (wb_valid_o && wb_ready_i)
    begin
      if (exp_data.size() == 0)
      begin
        fail_cnt++;
        $display("At %0t ns a write-back appeared with no instruction outstanding", $time);
      end
      else
      begin
        ea = exp_addr.pop_front();
        ed = exp_data.pop_front();
        if (wb_rf_waddr_o !== ea)
        begin
          mismatch_cnt++;
          $display("MISMATCH at %0t ns: wb_rf_waddr_o expected %0d got %0d",
                   $time, ea, wb_rf_waddr_o);
        end
        if (wb_rf_wdata_o !== ed)
        begin
          mismatch_cnt++;
          $display("MISMATCH at %0t ns: wb_rf_wdata_o expected %h got %h",
                   $time, ed, wb_rf_wdata_o);
        end
        if (wb_rf_we_o !== 1'b1)
        begin
          mismatch_cnt++;
          $display("MISMATCH at %0t ns: wb_rf_we_o expected 1 got %b", $time, wb_rf_we_o);
        end
      end
    end
    hold_q    = wb_valid_o && !wb_ready_i;
    hold_data = wb_rf_wdata_o;
    hold_addr = wb_rf_waddr_o;
  endtask

  task automatic report_and_finish();
    $display("Checks done: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table and main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    int   cyc;
    logic done;
    logic exp_rdy;
    logic exp_dec;
    seed = 32'h9365_9b8d;
    for (int k = 0; k < CSR_SCRATCH_NUM; k++)
      csr_model[k] = '0;
    rst_n      = 1'b0;
    halt_i     = 1'b0;
    wb_ready_i = 1'b1;
    idle_inputs();

    // ALU, signed and unsigned compares with negative operands
    add_entry(K_ALU, ALU_ADD,  MUL_LO, CSR_OP_READ, 32'h0000_0005, 32'h0000_0007, 5'd1, -1, 32'h0000_000C);
    add_entry(K_ALU, ALU_SUB,  MUL_LO, CSR_OP_READ, 32'h0000_0005, 32'h0000_0007, 5'd2, -1, 32'hFFFF_FFFE);
    add_entry(K_ALU, ALU_AND,  MUL_LO, CSR_OP_READ, 32'hF0F0_1234, 32'h0FF0_FF00, 5'd3, -1, 32'h00F0_1200);
    add_entry(K_ALU, ALU_OR,   MUL_LO, CSR_OP_READ, 32'hF0F0_0000, 32'h0F0F_00FF, 5'd4, -1, 32'hFFFF_00FF);
    add_entry(K_ALU, ALU_XOR,  MUL_LO, CSR_OP_READ, 32'hAAAA_5555, 32'hFFFF_0000, 5'd5, -1, 32'h5555_5555);
    // Shift amount uses only the low five bits of b
    add_entry(K_ALU, ALU_SLL,  MUL_LO, CSR_OP_READ, 32'h0000_0001, 32'h0000_0024, 5'd6, -1, 32'h0000_0010);
    add_entry(K_ALU, ALU_SRL,  MUL_LO, CSR_OP_READ, 32'h8000_0000, 32'h0000_0004, 5'd7, -1, 32'h0800_0000);
    add_entry(K_ALU, ALU_SRA,  MUL_LO, CSR_OP_READ, 32'h8000_0000, 32'h0000_0004, 5'd8, -1, 32'hF800_0000);
    add_entry(K_ALU, ALU_SLT,  MUL_LO, CSR_OP_READ, 32'hFFFF_FFFF, 32'h0000_0001, 5'd9, -1, 32'h0000_0001);
    add_entry(K_ALU, ALU_SLTU, MUL_LO, CSR_OP_READ, 32'hFFFF_FFFF, 32'h0000_0001, 5'd10, -1, 32'h0);
    add_entry(K_ALU, ALU_SLT,  MUL_LO, CSR_OP_READ, 32'h0000_0001, 32'h8000_0000, 5'd11, -1, 32'h0);
    add_entry(K_ALU, ALU_SLTU, MUL_LO, CSR_OP_READ, 32'h0000_0001, 32'h8000_0000, 5'd12, -1, 32'h1);
    // Multiplier, back to back, low and unsigned high halves
    add_entry(K_MUL, ALU_ADD, MUL_LO, CSR_OP_READ, 32'h0001_0003, 32'h0002_0005, 5'd13, -1, 32'h000B_000F);
    add_entry(K_MUL, ALU_ADD, MUL_HU, CSR_OP_READ, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 5'd14, -1, 32'hFFFF_FFFE);
    add_entry(K_MUL, ALU_ADD, MUL_LO, CSR_OP_READ, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 5'd15, -1, 32'h0000_0001);
    // CSR traffic, same address always split by an ALU or MUL entry
    add_entry(K_CSR, ALU_ADD, MUL_LO, CSR_OP_WRITE, 32'hDEAD_BEEF, 32'h340, 5'd16, -1, 32'h0);
    add_entry(K_ALU, ALU_ADD, MUL_LO, CSR_OP_READ,  32'h7FFF_FFFF, 32'h1,   5'd17, -1, 32'h8000_0000);
    add_entry(K_CSR, ALU_ADD, MUL_LO, CSR_OP_SET,   32'h0000_00F0, 32'h340, 5'd18, -1, 32'h0);
    add_entry(K_CSR, ALU_ADD, MUL_LO, CSR_OP_WRITE, 32'h1234_5678, 32'h343, 5'd19, -1, 32'h0);
    add_entry(K_MUL, ALU_ADD, MUL_LO, CSR_OP_READ,  32'h0000_0010, 32'h10,  5'd20, -1, 32'h0000_0100);
    add_entry(K_CSR, ALU_ADD, MUL_LO, CSR_OP_CLEAR, 32'h0000_000F, 32'h340, 5'd21, -1, 32'h0);
    add_entry(K_CSR, ALU_ADD, MUL_LO, CSR_OP_WRITE, 32'h5555_5555, 32'h344, 5'd22, -1, 32'h0);
    add_entry(K_ALU, ALU_SUB, MUL_LO, CSR_OP_READ,  32'h0000_0000, 32'h1,   5'd23, -1, 32'hFFFF_FFFF);
    add_entry(K_CSR, ALU_ADD, MUL_LO, CSR_OP_READ,  32'h0000_0000, 32'h344, 5'd24, -1, 32'h0);
    add_entry(K_CSR, ALU_ADD, MUL_LO, CSR_OP_READ,  32'h0000_0000, 32'h343, 5'd25, -1, 32'h0);
    add_entry(K_ALU, ALU_XOR, MUL_LO, CSR_OP_READ,  32'h0F0F_0F0F, 32'hFFFF, 5'd26, -1, 32'h0F0F_F0F0);
    add_entry(K_CSR, ALU_ADD, MUL_LO, CSR_OP_READ,  32'h0000_0000, 32'h340, 5'd27, -1, 32'h0);
    // Branches, want holds the taken decision
    add_entry(K_BR, ALU_EQ,   MUL_LO, CSR_OP_READ, 32'h0000_0005, 32'h0000_0005, 5'd0, -1, 32'h1);
    add_entry(K_BR, ALU_NE,   MUL_LO, CSR_OP_READ, 32'h0000_0005, 32'h0000_0005, 5'd0, -1, 32'h0);
    add_entry(K_BR, ALU_SLT,  MUL_LO, CSR_OP_READ, 32'hFFFF_FFF0, 32'h0000_0000, 5'd0, -1, 32'h1);
    add_entry(K_BR, ALU_SLTU, MUL_LO, CSR_OP_READ, 32'hFFFF_FFF0, 32'h0000_0000, 5'd0, -1, 32'h0);
    // Kill in the middle of a multiply and on an ALU entry
    add_entry(K_MUL, ALU_ADD, MUL_LO, CSR_OP_READ, 32'h0000_0003, 32'h0000_0004, 5'd28, 2, 32'h0);
    add_entry(K_ALU, ALU_ADD, MUL_LO, CSR_OP_READ, 32'h0000_0003, 32'h0000_0004, 5'd29, -1, 32'h7);
    add_entry(K_ALU, ALU_ADD, MUL_LO, CSR_OP_READ, 32'h0000_0001, 32'h0000_0001, 5'd30, 0, 32'h0);
    add_entry(K_MUL, ALU_ADD, MUL_HU, CSR_OP_READ, 32'h8000_0000, 32'h0000_0004, 5'd31, -1, 32'h2);

    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < tbl.size() && !timed_out; i++)
    begin
      cyc  = 0;
      done = 1'b0;
      while (!done && !timed_out)
      begin
        @(negedge clk);
        drive_entry(tbl[i], i, cyc);
        draw_wb_ready();
        #1;
        check_wb();
        // A multiply holds the stage for MULT_STEPS cycles, then follows writeback
        if (tbl[i].kind == K_BR)
          exp_rdy = 1'b1;
        else if (tbl[i].kind == K_MUL && cyc < MULT_STEPS)
          exp_rdy = 1'b0;
        else
          exp_rdy = wb_ready_i;
        if (ex_ready_o !== exp_rdy)
        begin
          mismatch_cnt++;
          $display("MISMATCH at %0t ns: ex_ready_o expected %b got %b",
                   $time, exp_rdy, ex_ready_o);
        end
        exp_dec = (tbl[i].kind == K_BR && !kill_i) ? tbl[i].want[0] : 1'b0;
        if (branch_decision_o !== exp_dec)
        begin
          mismatch_cnt++;
          $display("MISMATCH at %0t ns: branch_decision_o expected %b got %b",
                   $time, exp_dec, branch_decision_o);
        end
        if (branch_target_o !== branch_target_i)
        begin
          mismatch_cnt++;
          $display("MISMATCH at %0t ns: branch_target_o expected %h got %h",
                   $time, branch_target_i, branch_target_o);
        end
        // Killed entries are dropped, the next one follows right away
        if (kill_i)
          done = 1'b1;
        else if (ex_ready_o)
        begin
          record_accept(tbl[i]);
          done = 1'b1;
        end
        cyc++;
        if (!done && cyc >= TIMEOUT)
        begin
          fail_cnt++;
          timed_out = 1'b1;
          $display("Timeout: entry %0d was not accepted within %0d cycles", i, TIMEOUT);
        end
      end
    end

    // Drain the EX/WB register under the same random back-pressure
    if (!timed_out)
    begin
      @(negedge clk);
      idle_inputs();
      draw_wb_ready();
      #1;
      check_wb();
      cyc = 0;
      while (exp_data.size() != 0 && !timed_out)
      begin
        @(negedge clk);
        draw_wb_ready();
        #1;
        check_wb();
        cyc++;
        if (exp_data.size() != 0 && cyc >= TIMEOUT)
        begin
          fail_cnt++;
          timed_out = 1'b1;
          $display("Timeout: %0d write-backs never appeared", exp_data.size());
        end
      end
      // Quiet tail, any write-back here is spurious
      repeat (3)
      begin
        @(negedge clk);
        wb_ready_i = 1'b1;
        #1;
        check_wb();
      end
    end

    report_and_finish();
  end

endmodule

/* list.f */
common/ex_pkg.sv
hw/ex_stage/ex_alu.sv
hw/ex_stage/ex_mult.sv
hw/ex_stage/ex_stage.sv
hw/csr_scratch.sv
hw/ex_top.sv
verif/tb_ex_top.sv

/* run.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_ex_top -f list.f --Mdir obj_dir -o tb_ex_top

status=0
./obj_dir/tb_ex_top > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Result: FAILED" sim.log; then
  echo "Simulation did not pass, see sim.log"
  exit 1
fi
echo "Simulation finished cleanly"
